// ==== files.f ====
hw/dma_ctrl_pkg.sv
hw/dma_config_regs.sv
hw/dma_request_arbiter.sv
hw/dma_cycle_fsm.sv
hw/dma_bus_strobes.sv
hw/dma_timing_control.sv
tests/dma_timing_checker.sv
tests/tb_dma_timing_control.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exits non-zero unless the pass line appears

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f files.f --top-module tb_dma_timing_control -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_dma_timing_control)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

// ==== tests/tb_dma_timing_control.sv ====
// Rows run in order and rotation rows rely on the channel served by the row before; one bus master
`default_nettype none

module tb_dma_timing_control
    import dma_ctrl_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD   = 40;
    localparam int DRIVE_DELAY    = 5;
    localparam int SAMPLE_DELAY   = 20;
    localparam int RESET_CYCLES   = 16;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int SEED           = 28187;
    localparam int NUM_ROWS       = 8;

    // Word numbers count from 1, and 0 means never
    typedef struct packed {
        logic [7:0] cmd;
        logic [7:0] mode;
        chan_mask_t req;
        int         tc_word;
        int         eop_word;
        int         drop_word;
        int         exp_words;
        chan_mask_t exp_dack;
        bus_cmd_t   exp_cmd;
        chan_mask_t exp_tc;
    } scenario_t;

    // cmd, mode, req, tc, eop, drop, words, dack, bus cmd, tc status
    scenario_t scenarios [NUM_ROWS] = '{
        '{8'h80, 8'h46, 4'b0100, 0, 0, 1, 1, 4'b0100, 4'b0110, 4'b0000},
        '{8'h80, 8'h88, 4'b0001, 3, 0, 1, 3, 4'b0001, 4'b1001, 4'b0001},
        '{8'h80, 8'h44, 4'b1010, 0, 0, 1, 1, 4'b0010, 4'b0110, 4'b0000},
        '{8'h90, 8'h44, 4'b1010, 0, 0, 1, 1, 4'b1000, 4'b0110, 4'b0000},
        '{8'h90, 8'h44, 4'b1010, 0, 0, 1, 1, 4'b0010, 4'b0110, 4'b0000},
        '{8'h00, 8'h49, 4'b0010, 0, 0, 1, 1, 4'b1101, 4'b1001, 4'b0000},
        '{8'h80, 8'h93, 4'b1000, 0, 2, 1, 2, 4'b1000, 4'b0000, 4'b1000},
        '{8'h80, 8'h06, 4'b0100, 0, 0, 3, 3, 4'b0100, 4'b0110, 4'b0000}
    };

    logic       clock;
    logic       reset;
    logic [7:0] reg_data_i;
    logic       write_cmd_i;
    logic       write_mode_i;
    logic       master_clear_i;
    logic       read_status_i;
    chan_mask_t dreq_i;
    logic       hold_ack_i;
    logic       ready_i;
    logic       eop_i;
    logic       underflow_i;
    logic       update_high_i;
    logic       hrq_o;
    logic       aen_o;
    logic       adstb_o;
    chan_mask_t dack_o;
    bus_cmd_t   bus_cmd_o;
    logic       next_word_o;
    logic       init_current_o;
    logic       eop_o;
    chan_mask_t tc_status_o;
    chan_mask_t reg_select_o;

    int   error_count = 0;
    int   check_total = 0;
    logic timed_out   = 1'b0;

    dma_timing_control #(
        .CHANNELS (NUM_CHANNELS)
    ) uut (
        .clock          (clock),
        .reset          (reset),
        .reg_data_i     (reg_data_i),
        .write_cmd_i    (write_cmd_i),
        .write_mode_i   (write_mode_i),
        .master_clear_i (master_clear_i),
        .read_status_i  (read_status_i),
        .dreq_i         (dreq_i),
        .hold_ack_i     (hold_ack_i),
        .ready_i        (ready_i),
        .eop_i          (eop_i),
        .underflow_i    (underflow_i),
        .update_high_i  (update_high_i),
        .hrq_o          (hrq_o),
        .aen_o          (aen_o),
        .adstb_o        (adstb_o),
        .dack_o         (dack_o),
        .bus_cmd_o      (bus_cmd_o),
        .next_word_o    (next_word_o),
        .init_current_o (init_current_o),
        .eop_o          (eop_o),
        .tc_status_o    (tc_status_o),
        .reg_select_o   (reg_select_o)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // ========================================================================
    // Compare tasks
    // ========================================================================
    task automatic check_mask(input string what, input chan_mask_t got, input chan_mask_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_bus_cmd(input string what, input bus_cmd_t got, input bus_cmd_t exp);
        check_total++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR @%0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        check_total++;
        if (got != exp) begin
            error_count++;
            $display("ERROR @%0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // ========================================================================
    // Drivers
    // ========================================================================
    task automatic next_cycle();
        @(posedge clock);
        #DRIVE_DELAY;
    endtask

    task automatic rest_inputs();
        dreq_i        = '0;
        hold_ack_i    = 1'b0;
        ready_i       = 1'b1;
        eop_i         = 1'b0;
        underflow_i   = 1'b0;
        update_high_i = 1'b0;
        read_status_i = 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] data, input logic is_mode);
        next_cycle();
        reg_data_i   = data;
        write_cmd_i  = !is_mode;
        write_mode_i = is_mode;
        next_cycle();
        write_cmd_i  = 1'b0;
        write_mode_i = 1'b0;
    endtask

    // Levels for the word that comes next; ready and high-address update are random
    task automatic drive_transfer(input scenario_t row, input int words, input logic hold);
        hold_ack_i    = hold;
        dreq_i        = (words >= row.drop_word) ? '0 : row.req;
        underflow_i   = (words + 1 == row.tc_word);
        eop_i         = (words + 1 == row.eop_word);
        ready_i       = ($urandom_range(0, 3) != 0);
        update_high_i = ($urandom_range(0, 1) == 1);
    endtask

    // Master clear while a block read on channel 0 sits in a wait state
    task automatic clear_and_check();
        int cyc;

        write_reg(8'h00, 1'b0);
        write_reg(8'h88, 1'b1);
        next_cycle();
        dreq_i     = 4'b0001;
        hold_ack_i = 1'b1;
        ready_i    = 1'b0;
        for (cyc = 0; cyc < TIMEOUT_CYCLES; cyc++) begin
            next_cycle();
            if (bus_cmd_o.mem_read && bus_cmd_o.io_write) begin
                break;
            end
        end
        if (cyc == TIMEOUT_CYCLES) begin
            error_count++;
            timed_out = 1'b1;
            $display("Read transfer before master clear never raised its bus commands");
        end
        check_mask("dack_o before clear", dack_o, 4'b1110);
        master_clear_i = 1'b1;
        next_cycle();
        master_clear_i = 1'b0;
        rest_inputs();
        #SAMPLE_DELAY;
        check_count("hrq_o after clear", int'(hrq_o), 0);
        check_count("aen_o after clear", int'(aen_o), 0);
        check_count("adstb_o after clear", int'(adstb_o), 0);
        check_count("eop_o after clear", int'(eop_o), 0);
        check_mask("dack_o after clear", dack_o, '0);
        check_bus_cmd("bus_cmd_o after clear", bus_cmd_o, '0);
    endtask

    task automatic run_scenario(input int r);
        scenario_t  row;
        chan_mask_t active;
        int         words;
        int         eops;
        int         inits;
        int         adstbs;
        int         highs;
        int         ack_wait;
        int         exp_eop;
        logic       last_high;
        logic       seen_hrq;
        logic       hold_next;
        logic       done;

        row       = scenarios[r];
        active    = row.cmd[7] ? row.exp_dack : ~row.exp_dack;
        exp_eop   = (row.tc_word != 0 || row.eop_word != 0) ? 1 : 0;
        words     = 0;
        eops      = 0;
        inits     = 0;
        adstbs    = 0;
        highs     = 0;
        ack_wait  = -1;
        last_high = 1'b0;
        seen_hrq  = 1'b0;
        done      = 1'b0;

        write_reg(row.cmd, 1'b0);
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (row.req[ch]) begin
                write_reg({row.mode[7:2], chan_idx_t'(ch)}, 1'b1);
            end
        end
        next_cycle();
        drive_transfer(row, words, 1'b0);

        for (int cyc = 0; cyc < TIMEOUT_CYCLES && !done; cyc++) begin
            #SAMPLE_DELAY;
            if (next_word_o) begin
                words++;
                highs    += int'(update_high_i);
                last_high = update_high_i;
                check_mask("dack_o in transfer", dack_o, row.exp_dack);
                check_mask("reg_select_o in transfer", reg_select_o, active);
                check_bus_cmd("bus_cmd_o in transfer", bus_cmd_o, row.exp_cmd);
                check_count("aen_o in transfer", int'(aen_o), 1);
            end
            eops   += int'(eop_o);
            inits  += int'(init_current_o);
            adstbs += int'(adstb_o);
            // Hold acknowledge follows hrq_o after 1 to 4 cycles
            if (hrq_o) begin
                seen_hrq = 1'b1;
                if (ack_wait < 0) begin
                    ack_wait = $urandom_range(0, 3);
                end else if (ack_wait > 0) begin
                    ack_wait--;
                end
            end else if (seen_hrq) begin
                done = 1'b1;
            end
            hold_next = seen_hrq && (ack_wait == 0);
            if (!done) begin
                next_cycle();
                drive_transfer(row, words, hold_next);
            end
        end

        if (!done) begin
            error_count++;
            timed_out = 1'b1;
            $display("Scenario %0d did not return to idle within %0d cycles", r, TIMEOUT_CYCLES);
        end else begin
            check_count("next_word_o pulses", words, row.exp_words);
            check_count("eop_o pulses", eops, exp_eop);
            check_count("init_current_o pulses", inits, row.mode[4] ? exp_eop : 0);
            // One address phase to start, then one per high-address update between words
            check_count("adstb_o pulses", adstbs, 1 + highs - int'(last_high));
            check_mask("dack_o in idle", dack_o, row.cmd[7] ? '0 : '1);
            check_mask("tc_status_o after transfer", tc_status_o, row.exp_tc);
            next_cycle();
            rest_inputs();
            read_status_i = 1'b1;
            next_cycle();
            read_status_i = 1'b0;
            #SAMPLE_DELAY;
            check_mask("tc_status_o after status read", tc_status_o, '0);
        end
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        void'($urandom(SEED));
        reset          = 1'b1;
        reg_data_i     = '0;
        write_cmd_i    = 1'b0;
        write_mode_i   = 1'b0;
        master_clear_i = 1'b0;
        rest_inputs();
        repeat (RESET_CYCLES) @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        clear_and_check();
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!timed_out) begin
                run_scenario(r);
            end
        end

        $display("Checks run: %0d, errors: %0d", check_total, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/dma_timing_checker.sv ====
// Checks bus protocol invariants only; data values and channel choice are left to the testbench
`default_nettype none

module dma_timing_checker
    import dma_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        hrq_i,
    input  logic        aen_i,
    input  logic        adstb_i,
    input  logic        eop_i,
    input  bus_cmd_t    bus_cmd_i,
    input  cycle_ctrl_t cycle_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Address strobe only in the setup cycle after an address phase, with the bus enabled
    adstb_in_aen: assert property (@(posedge clock) disable iff (reset)
        adstb_i |-> (aen_i && (cycle_i.state == ST_SETUP)))
        else $error("adstb_o high outside the cycle after ST_ADDRESS or with aen_o low");

    no_mem_to_mem: assert property (@(posedge clock) disable iff (reset)
        !(bus_cmd_i.mem_read && bus_cmd_i.mem_write))
        else $error("mem_read and mem_write high together");

    // End of process closes the transfer on the next edge
    eop_single_cycle: assert property (@(posedge clock) disable iff (reset)
        eop_i |=> (!eop_i && (cycle_i.state == ST_IDLE)))
        else $error("eop_o held longer than one cycle or transfer not ended");

    // Bus request covers every state outside idle
    hrq_held: assert property (@(posedge clock) disable iff (reset)
        (cycle_i.state != ST_IDLE) |-> hrq_i)
        else $error("hrq_o low before the return to idle");

endmodule

bind dma_timing_control dma_timing_checker u_timing_checker (
    .clock     (clock),
    .reset     (reset),
    .hrq_i     (hrq_o),
    .aen_i     (aen_o),
    .adstb_i   (adstb_o),
    .eop_i     (eop_o),
    .bus_cmd_i (bus_cmd_o),
    .cycle_i   (cycle)
);

`default_nettype wire

// ==== hw/dma_timing_control.sv ====
// Address and count registers live outside, so underflow_i and update_high_i must be valid at next_word_o
`default_nettype none

module dma_timing_control
    import dma_ctrl_pkg::*;
#(
    parameter int CHANNELS = NUM_CHANNELS
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] reg_data_i,
    input  logic       write_cmd_i,
    input  logic       write_mode_i,
    input  logic       master_clear_i,
    input  logic       read_status_i,
    input  chan_mask_t dreq_i,
    input  logic       hold_ack_i,
    input  logic       ready_i,
    input  logic       eop_i,
    input  logic       underflow_i,
    input  logic       update_high_i,
    output logic       hrq_o,
    output logic       aen_o,
    output logic       adstb_o,
    output chan_mask_t dack_o,
    output bus_cmd_t   bus_cmd_o,
    output logic       next_word_o,
    output logic       init_current_o,
    output logic       eop_o,
    output chan_mask_t tc_status_o,
    output chan_mask_t reg_select_o
);

    cmd_cfg_t    cmd_cfg;
    mode_cfg_t   mode_cfg [CHANNELS];
    chan_mask_t  grant;
    chan_idx_t   last_served;
    cycle_ctrl_t cycle;
    chan_mask_t  ack_chan;
    mode_cfg_t   sel_mode;

    dma_config_regs #(
        .CHANNELS (CHANNELS)
    ) u_config_regs (
        .clock          (clock),
        .reset          (reset),
        .reg_data_i     (reg_data_i),
        .write_cmd_i    (write_cmd_i),
        .write_mode_i   (write_mode_i),
        .master_clear_i (master_clear_i),
        .cmd_cfg_o      (cmd_cfg),
        .mode_cfg_o     (mode_cfg)
    );

    dma_request_arbiter #(
        .CHANNELS (CHANNELS)
    ) u_request_arbiter (
        .clock         (clock),
        .reset         (reset),
        .dreq_i        (dreq_i),
        .rotate_i      (cmd_cfg.rotate_priority),
        .last_served_i (last_served),
        .grant_o       (grant)
    );

    dma_cycle_fsm #(
        .CHANNELS (CHANNELS)
    ) u_cycle_fsm (
        .clock          (clock),
        .reset          (reset),
        .master_clear_i (master_clear_i),
        .grant_i        (grant),
        .mode_cfg_i     (mode_cfg),
        .dreq_i         (dreq_i),
        .hold_ack_i     (hold_ack_i),
        .ready_i        (ready_i),
        .eop_i          (eop_i),
        .underflow_i    (underflow_i),
        .update_high_i  (update_high_i),
        .read_status_i  (read_status_i),
        .cycle_o        (cycle),
        .ack_chan_o     (ack_chan),
        .sel_mode_o     (sel_mode),
        .last_served_o  (last_served),
        .reg_select_o   (reg_select_o),
        .next_word_o    (next_word_o),
        .init_current_o (init_current_o),
        .eop_o          (eop_o),
        .tc_status_o    (tc_status_o)
    );

    dma_bus_strobes u_bus_strobes (
        .clock              (clock),
        .reset              (reset),
        .master_clear_i     (master_clear_i),
        .cycle_i            (cycle),
        .sel_mode_i         (sel_mode),
        .ack_chan_i         (ack_chan),
        .dack_active_high_i (cmd_cfg.dack_active_high),
        .hrq_o              (hrq_o),
        .aen_o              (aen_o),
        .adstb_o            (adstb_o),
        .dack_o             (dack_o),
        .bus_cmd_o          (bus_cmd_o)
    );

endmodule

`default_nettype wire

// ==== hw/dma_bus_strobes.sv ====
// All strobes are active high and registered from the FSM state; only the DACK polarity is applied after the flop
`default_nettype none

module dma_bus_strobes
    import dma_ctrl_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        master_clear_i,
    input  cycle_ctrl_t cycle_i,
    input  mode_cfg_t   sel_mode_i,
    input  chan_mask_t  ack_chan_i,
    input  logic        dack_active_high_i,
    output logic        hrq_o,
    output logic        aen_o,
    output logic        adstb_o,
    output chan_mask_t  dack_o,
    output bus_cmd_t    bus_cmd_o
);

    chan_mask_t dack_q;

    // ========================================================================
    // Bus ownership
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            hrq_o   <= 1'b0;
            aen_o   <= 1'b0;
            adstb_o <= 1'b0;
            dack_q  <= '0;
        end else if (master_clear_i) begin
            hrq_o   <= 1'b0;
            aen_o   <= 1'b0;
            adstb_o <= 1'b0;
            dack_q  <= '0;
        end else begin
            // Rises with the grant edge, drops on the return to idle
            hrq_o   <= !cycle_i.entering_idle;
            adstb_o <= (cycle_i.state == ST_ADDRESS);
            if (cycle_i.entering_idle) begin
                aen_o <= 1'b0;
            end else if (cycle_i.state == ST_ADDRESS) begin
                aen_o <= 1'b1;
            end
            if (cycle_i.entering_idle) begin
                dack_q <= '0;
            end else if (cycle_i.entering_setup) begin
                dack_q <= ack_chan_i;
            end
        end
    end

    assign dack_o = dack_active_high_i ? dack_q : ~dack_q;

    // ========================================================================
    // Memory and I/O commands
    // ========================================================================
    // Source side opens after setup, destination side one cycle later
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            bus_cmd_o <= '0;
        end else if (master_clear_i) begin
            bus_cmd_o <= '0;
        end else begin
            case (cycle_i.state)
                ST_SETUP: begin
                    if (sel_mode_i.xfer_type == XFER_WRITE) begin
                        bus_cmd_o.io_read <= 1'b1;
                    end else if (sel_mode_i.xfer_type == XFER_READ) begin
                        bus_cmd_o.mem_read <= 1'b1;
                    end
                end
                ST_TRANSFER: begin
                    if (sel_mode_i.xfer_type == XFER_WRITE) begin
                        bus_cmd_o.mem_write <= 1'b1;
                    end else if (sel_mode_i.xfer_type == XFER_READ) begin
                        bus_cmd_o.io_write <= 1'b1;
                    end
                end
                ST_COMPLETE: bus_cmd_o <= '0;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/dma_cycle_fsm.sv ====
// Cascade mode runs as a single transfer, and the count underflow and high-address update come from outside
`default_nettype none

module dma_cycle_fsm
    import dma_ctrl_pkg::*;
#(
    parameter int CHANNELS = NUM_CHANNELS
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        master_clear_i,
    input  chan_mask_t  grant_i,
    input  mode_cfg_t   mode_cfg_i [CHANNELS],
    input  chan_mask_t  dreq_i,
    input  logic        hold_ack_i,
    input  logic        ready_i,
    input  logic        eop_i,
    input  logic        underflow_i,
    input  logic        update_high_i,
    input  logic        read_status_i,
    output cycle_ctrl_t cycle_o,
    output chan_mask_t  ack_chan_o,
    output mode_cfg_t   sel_mode_o,
    output chan_idx_t   last_served_o,
    output chan_mask_t  reg_select_o,
    output logic        next_word_o,
    output logic        init_current_o,
    output logic        eop_o,
    output chan_mask_t  tc_status_o
);

    dma_state_e state;
    dma_state_e next_state;
    chan_idx_t  sel_idx;
    logic       tc_flag;
    logic       ext_flag;
    logic       high_update;
    logic       one_word;
    logic       demand_done;

    // One-hot acknowledge to channel number
    always_comb begin
        sel_idx = '0;
        for (int c = 0; c < CHANNELS; c++) begin
            if (ack_chan_o[c]) begin
                sel_idx = chan_idx_t'(c);
            end
        end
    end

    assign sel_mode_o  = mode_cfg_i[sel_idx];
    assign one_word    = (sel_mode_o.mode == MODE_SINGLE) || (sel_mode_o.mode == MODE_CASCADE);
    assign demand_done = (sel_mode_o.mode == MODE_DEMAND) && ((ack_chan_o & dreq_i) == '0);

    // ========================================================================
    // Next state
    // ========================================================================
    always_comb begin
        next_state = state;
        unique case (state)
            ST_IDLE: begin
                if (grant_i != '0) begin
                    next_state = ST_HOLD_WAIT;
                end
            end
            ST_HOLD_WAIT: begin
                if (hold_ack_i) begin
                    next_state = ST_ADDRESS;
                end
            end
            ST_ADDRESS:  next_state = ST_SETUP;
            ST_SETUP:    next_state = ST_TRANSFER;
            ST_TRANSFER: next_state = ST_WAIT;
            ST_WAIT: begin
                if (ready_i) begin
                    next_state = ST_COMPLETE;
                end
            end
            ST_COMPLETE: begin
                if (one_word || eop_o || demand_done) begin
                    next_state = ST_IDLE;
                end else if (high_update) begin
                    next_state = ST_ADDRESS;
                end else begin
                    next_state = ST_SETUP;
                end
            end
            default: next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state         <= ST_IDLE;
            ack_chan_o    <= '0;
            last_served_o <= chan_idx_t'(CHANNELS - 1);
        end else if (master_clear_i) begin
            state         <= ST_IDLE;
            ack_chan_o    <= '0;
            last_served_o <= chan_idx_t'(CHANNELS - 1);
        end else begin
            state <= next_state;
            if (state == ST_IDLE) begin
                ack_chan_o <= grant_i;
            end
            // Rotation point moves on hold acknowledge
            if ((state == ST_HOLD_WAIT) && hold_ack_i) begin
                last_served_o <= sel_idx;
            end
        end
    end

    // ========================================================================
    // End of process and status
    // ========================================================================
    assign next_word_o = (next_state == ST_COMPLETE);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tc_flag     <= 1'b0;
            ext_flag    <= 1'b0;
            high_update <= 1'b0;
        end else if (master_clear_i) begin
            tc_flag     <= 1'b0;
            ext_flag    <= 1'b0;
            high_update <= 1'b0;
        end else begin
            if (state == ST_COMPLETE) begin
                tc_flag <= 1'b0;
            end else if (next_word_o) begin
                tc_flag <= underflow_i;
            end
            if (state == ST_IDLE) begin
                ext_flag <= 1'b0;
            end else if ((next_state == ST_SETUP) && eop_i) begin
                ext_flag <= 1'b1;
            end
            if (next_word_o) begin
                high_update <= update_high_i;
            end
        end
    end

    assign eop_o          = (state == ST_COMPLETE) && (tc_flag || ext_flag);
    assign init_current_o = eop_o && sel_mode_o.autoinit;
    assign reg_select_o   = (state != ST_IDLE) ? ack_chan_o : '0;

    // A status read and a new terminal count on the same edge keep the new bit
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            tc_status_o <= '0;
        end else if (master_clear_i) begin
            tc_status_o <= '0;
        end else begin
            tc_status_o <= (read_status_i ? '0 : tc_status_o) | (eop_o ? ack_chan_o : '0);
        end
    end

    assign cycle_o = '{
        state:          state,
        entering_setup: (next_state == ST_SETUP),
        entering_idle:  (next_state == ST_IDLE)
    };

endmodule

`default_nettype wire

// ==== hw/dma_request_arbiter.sv ====
// Requests are levels and the grant is only used by the FSM in idle, so the grant is purely combinational
`default_nettype none

module dma_request_arbiter
    import dma_ctrl_pkg::*;
#(
    parameter int CHANNELS = NUM_CHANNELS
) (
    input  logic       clock,
    input  logic       reset,
    input  chan_mask_t dreq_i,
    input  logic       rotate_i,
    input  chan_idx_t  last_served_i,
    output chan_mask_t grant_o
);

    chan_idx_t pointer;

    // Follows the channel taken at hold acknowledge
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pointer <= chan_idx_t'(CHANNELS - 1);
        end else if (last_served_i != pointer) begin
            pointer <= last_served_i;
        end
    end

    // Search upward from one past the start point, wrapping around
    always_comb begin
        int   start;
        int   idx;
        logic found;

        // Fixed priority behaves as if the last channel was just served
        start   = rotate_i ? int'(pointer) : CHANNELS - 1;
        found   = 1'b0;
        grant_o = '0;
        for (int i = 1; i <= CHANNELS; i++) begin
            idx = (start + i) % CHANNELS;
            if (!found && dreq_i[idx]) begin
                grant_o[idx] = 1'b1;
                found        = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dma_config_regs.sv ====
// Register writes are single-cycle strobes with no handshake; the mode write picks its channel from data bits 1:0
`default_nettype none

module dma_config_regs
    import dma_ctrl_pkg::*;
#(
    parameter int CHANNELS = NUM_CHANNELS
) (
    input  logic      clock,
    input  logic      reset,
    input  logic [7:0] reg_data_i,
    input  logic      write_cmd_i,
    input  logic      write_mode_i,
    input  logic      master_clear_i,
    output cmd_cfg_t  cmd_cfg_o,
    output mode_cfg_t mode_cfg_o [CHANNELS]
);

    // DACK defaults to active high
    localparam cmd_cfg_t CMD_RESET = '{rotate_priority: 1'b0, dack_active_high: 1'b1};

    localparam mode_cfg_t MODE_RESET = '{
        xfer_type: XFER_VERIFY,
        autoinit:  1'b0,
        decrement: 1'b0,
        mode:      MODE_DEMAND
    };

    // ========================================================================
    // Command register
    // ========================================================================
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            cmd_cfg_o <= CMD_RESET;
        end else if (master_clear_i) begin
            cmd_cfg_o <= CMD_RESET;
        end else if (write_cmd_i) begin
            cmd_cfg_o.rotate_priority  <= reg_data_i[4];
            cmd_cfg_o.dack_active_high <= reg_data_i[7];
        end
    end

    // ========================================================================
    // Mode registers, one per channel
    // ========================================================================
    for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_mode
        always_ff @(posedge clock or posedge reset) begin
            if (reset) begin
                mode_cfg_o[ch] <= MODE_RESET;
            end else if (master_clear_i) begin
                mode_cfg_o[ch] <= MODE_RESET;
            end else if (write_mode_i && (reg_data_i[1:0] == chan_idx_t'(ch))) begin
                // Cascade code is kept as written
                mode_cfg_o[ch] <= '{
                    xfer_type: xfer_type_e'(reg_data_i[3:2]),
                    autoinit:  reg_data_i[4],
                    decrement: reg_data_i[5],
                    mode:      xfer_mode_e'(reg_data_i[7:6])
                };
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/dma_ctrl_pkg.sv ====
// Channel count is tied to the 2-bit channel index; transfer type code 3 is illegal and acts as verify
`default_nettype none

package dma_ctrl_pkg;

    localparam int NUM_CHANNELS = 4;

    typedef logic [$clog2(NUM_CHANNELS)-1:0] chan_idx_t;
    typedef logic [NUM_CHANNELS-1:0]         chan_mask_t;

    // Mode register bits 3:2
    typedef enum logic [1:0] {
        XFER_VERIFY = 2'd0,
        XFER_WRITE  = 2'd1,
        XFER_READ   = 2'd2
    } xfer_type_e;

    // Mode register bits 7:6
    typedef enum logic [1:0] {
        MODE_DEMAND  = 2'd0,
        MODE_SINGLE  = 2'd1,
        MODE_BLOCK   = 2'd2,
        MODE_CASCADE = 2'd3
    } xfer_mode_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HOLD_WAIT,
        ST_ADDRESS,
        ST_SETUP,
        ST_TRANSFER,
        ST_WAIT,
        ST_COMPLETE
    } dma_state_e;

    typedef struct packed {
        logic rotate_priority;
        logic dack_active_high;
    } cmd_cfg_t;

    typedef struct packed {
        xfer_type_e xfer_type;
        logic       autoinit;
        logic       decrement;
        xfer_mode_e mode;
    } mode_cfg_t;

    typedef struct packed {
        logic mem_read;
        logic mem_write;
        logic io_read;
        logic io_write;
    } bus_cmd_t;

    // Flags look one edge ahead so the strobes can register on entry
    typedef struct packed {
        dma_state_e state;
        logic       entering_setup;
        logic       entering_idle;
    } cycle_ctrl_t;

endpackage

`default_nettype wire
